//--- rtl/gmii_gen_defines.svh
`ifndef GMII_GEN_DEFINES_SVH
`define GMII_GEN_DEFINES_SVH

// --------------------------------------------------
// gmii line bytes
// --------------------------------------------------
`define GMII_PREAMBLE_BYTE   8'h55
`define GMII_SFD_BYTE        8'hD5
`define GMII_SFD_ERR_BYTE    8'hF5          // sfd with bit 5 flipped

// --------------------------------------------------
// ethernet framing
// --------------------------------------------------
`define ETH_VLAN_TPID        16'h8100
`define ETH_MAC_BYTES        6
`define ETH_MIN_FRAME_BYTES  60             // dst through last pad byte
`define ETH_FCS_BYTES        4

// crc-32 with reflected input
`define CRC32_POLY           32'h04C11DB7
`define CRC32_INIT           32'hFFFF_FFFF
`define FCS_ERR_INDEX        2              // fcs byte flipped on crc error

`endif

//--- rtl/gmii_gen_pkg.sv
package gmii_gen_pkg;

   // --------------------------------------------------
   // frame command captured on start
   // --------------------------------------------------
   typedef struct packed {
      logic        mac_reverse;   // addresses msb byte first
      logic [47:0] dst;
      logic [47:0] src;
      logic [4:0]  prmble_len;
      logic        vlan_en;
      logic [15:0] vlan_ctl;
      logic [15:0] len;           // payload bytes
      logic [15:0] frmtype;       // non-zero replaces len on the wire
      logic [7:0]  cntstart;
      logic [7:0]  cntstep;
      logic [15:0] ipg_len;
      logic        prmbl_err;
      logic        crc_err;
      logic        pad_en;
   } frame_cmd_t;

   // what a stream byte is, for the crc stage
   typedef enum logic [1:0] {
      KIND_PREAMBLE = 2'd0,       // preamble and sfd, outside crc
      KIND_COVERED  = 2'd1,       // header, payload, pad
      KIND_FCS      = 2'd2
   } byte_kind_e;

   // one byte per cycle between stages
   typedef struct packed {
      logic       valid;
      byte_kind_e kind;
      logic [7:0] data;
      logic       first;
      logic       last;
   } gmii_beat_t;

endpackage

//--- rtl/frame_sequencer.sv
`include "gmii_gen_defines.svh"

module frame_sequencer (
   input  logic                     rx_clk_gen,
   input  logic                     reset,
   input  logic                     start_i,
   input  gmii_gen_pkg::frame_cmd_t cmd_i,
   output gmii_gen_pkg::gmii_beat_t beat_o,
   output logic                     done_o,
   output logic                     crc_err_o
);
   import gmii_gen_pkg::*;

   // dst, src, tag, length field and the largest payload
   localparam int unsigned POS_LIMIT = 2 * `ETH_MAC_BYTES + 4 + 2 + 65535;

   typedef enum logic [3:0] {
      S_IDLE,
      S_PRMBL,
      S_SFD,
      S_DST,
      S_SRC,
      S_TAG,
      S_LEN,
      S_DATA,
      S_PAD,
      S_FCS,
      S_GAP
   } state_e;

   state_e      state;
   frame_cmd_t  cmd_q;
   logic [15:0] cnt;               // byte counter within a state
   logic [15:0] cnt_inc;
   logic [16:0] pos_cnt;           // from first dst byte
   logic [7:0]  datacnt;           // payload pattern from byte 2 on
   logic        first_pend;
   logic        pad_short;
   logic [2:0]  mac_idx;
   logic [31:0] tag_word;
   logic [15:0] len_field;
   logic        valid_nxt;
   byte_kind_e  kind_nxt;
   logic [7:0]  data_nxt;
   logic        last_nxt;

   assign cnt_inc   = cnt + 16'd1;
   assign pad_short = cmd_q.pad_en && (pos_cnt < 17'(`ETH_MIN_FRAME_BYTES - 1));
   assign mac_idx   = cmd_q.mac_reverse ? 3'(`ETH_MAC_BYTES - 1) - cnt[2:0] : cnt[2:0];
   assign tag_word  = {`ETH_VLAN_TPID, cmd_q.vlan_ctl};
   assign len_field = (cmd_q.frmtype != 16'd0) ? cmd_q.frmtype : cmd_q.len;
   assign crc_err_o = cmd_q.crc_err;

   // --------------------------------------------------
   // command capture and payload counter
   // --------------------------------------------------
   always_ff @(posedge rx_clk_gen)
   begin
      if (state == S_IDLE && start_i)
         cmd_q <= cmd_i;
      if (state == S_DATA)
      begin
         if (cnt == 16'd0)
            datacnt <= cmd_q.cntstart;
         else if (cnt != 16'd1)
            datacnt <= datacnt + cmd_q.cntstep;
      end
   end

   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
         pos_cnt <= '0;
      else if (state == S_IDLE && start_i)
         pos_cnt <= '0;
      else if (valid_nxt && kind_nxt == KIND_COVERED)
         pos_cnt <= pos_cnt + 17'd1;
   end

   // byte for the current state
   always_comb
   begin
      valid_nxt = 1'b1;
      kind_nxt  = KIND_COVERED;
      data_nxt  = 8'h00;
      last_nxt  = 1'b0;
      case (state)
         S_PRMBL:
         begin
            kind_nxt = KIND_PREAMBLE;
            data_nxt = `GMII_PREAMBLE_BYTE;
         end
         S_SFD:
         begin
            kind_nxt = KIND_PREAMBLE;
            data_nxt = cmd_q.prmbl_err ? `GMII_SFD_ERR_BYTE : `GMII_SFD_BYTE;
         end
         S_DST:  data_nxt = cmd_q.dst[{mac_idx, 3'b000} +: 8];
         S_SRC:  data_nxt = cmd_q.src[{mac_idx, 3'b000} +: 8];
         S_TAG:  data_nxt = tag_word[{~cnt[1:0], 3'b000} +: 8];   // tpid first
         S_LEN:  data_nxt = cnt[0] ? len_field[7:0] : len_field[15:8];
         S_DATA:
         begin
            if (cnt == 16'd0)
               data_nxt = cmd_q.cntstart;
            else if (cnt == 16'd1)
               data_nxt = cmd_q.cntstep;
            else
               data_nxt = datacnt;
         end
         S_PAD:  data_nxt = 8'h00;
         S_FCS:
         begin
            kind_nxt = KIND_FCS;   // filled in downstream
            last_nxt = (cnt_inc == 16'(`ETH_FCS_BYTES));
         end
         default: valid_nxt = 1'b0;
      endcase
   end

   // --------------------------------------------------
   // frame state machine
   // --------------------------------------------------
   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
      begin
         state      <= S_IDLE;
         cnt        <= '0;
         first_pend <= 1'b0;
         done_o     <= 1'b1;
         beat_o     <= '0;
      end
      else
      begin
         beat_o.valid <= valid_nxt;
         beat_o.kind  <= kind_nxt;
         beat_o.data  <= data_nxt;
         beat_o.first <= first_pend && valid_nxt;
         beat_o.last  <= last_nxt;
         if (valid_nxt)
            first_pend <= 1'b0;
         cnt <= cnt_inc;
         case (state)
            S_IDLE:
            begin
               cnt <= '0;
               if (start_i)
               begin
                  first_pend <= 1'b1;
                  done_o     <= 1'b0;
                  state      <= (cmd_i.prmble_len == 5'd0) ? S_SFD : S_PRMBL;
               end
            end
            S_PRMBL:
            begin
               if (cnt_inc == 16'(cmd_q.prmble_len))
               begin
                  state <= S_SFD;
                  cnt   <= '0;
               end
            end
            S_SFD:
            begin
               state <= S_DST;
               cnt   <= '0;
            end
            S_DST:
            begin
               if (cnt_inc == 16'(`ETH_MAC_BYTES))
               begin
                  state <= S_SRC;
                  cnt   <= '0;
               end
            end
            S_SRC:
            begin
               if (cnt_inc == 16'(`ETH_MAC_BYTES))
               begin
                  state <= cmd_q.vlan_en ? S_TAG : S_LEN;
                  cnt   <= '0;
               end
            end
            S_TAG:
            begin
               if (cnt_inc == 16'd4)   // tpid and tci
               begin
                  state <= S_LEN;
                  cnt   <= '0;
               end
            end
            S_LEN:
            begin
               if (cnt_inc == 16'd2)
               begin
                  cnt <= '0;
                  if (cmd_q.len != 16'd0)
                     state <= S_DATA;
                  else
                     state <= pad_short ? S_PAD : S_FCS;   // empty payload
               end
            end
            S_DATA:
            begin
               if (cnt_inc == cmd_q.len)
               begin
                  state <= pad_short ? S_PAD : S_FCS;
                  cnt   <= '0;
               end
            end
            S_PAD:
            begin
               if (pos_cnt == 17'(`ETH_MIN_FRAME_BYTES - 1))
               begin
                  state <= S_FCS;
                  cnt   <= '0;
               end
            end
            S_FCS:
            begin
               if (cnt_inc == 16'(`ETH_FCS_BYTES))
               begin
                  cnt <= '0;
                  if (cmd_q.ipg_len != 16'd0)
                     state <= S_GAP;
                  else
                  begin
                     state  <= S_IDLE;
                     done_o <= 1'b1;
                  end
               end
            end
            S_GAP:
            begin
               if (cnt_inc == cmd_q.ipg_len)
               begin
                  state  <= S_IDLE;
                  done_o <= 1'b1;
                  cnt    <= '0;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   a_start_idle : assert property (@(posedge rx_clk_gen) disable iff (reset)
      start_i |-> state == S_IDLE);

   a_pos_limit : assert property (@(posedge rx_clk_gen) disable iff (reset)
      pos_cnt <= 17'(POS_LIMIT));

endmodule

//--- rtl/fcs_inserter.sv
`include "gmii_gen_defines.svh"

module fcs_inserter (
   input  logic                     rx_clk_gen,
   input  logic                     reset,
   input  gmii_gen_pkg::gmii_beat_t beat_i,
   input  logic                     crc_err_i,
   output gmii_gen_pkg::gmii_beat_t beat_o
);
   import gmii_gen_pkg::*;

   logic [31:0] crc;
   logic [1:0]  fcs_idx;           // which fcs byte is next
   logic [7:0]  fcs_byte;
   logic        is_fcs;

   // one byte fed lsb first
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                              input logic [7:0]  d);
      logic [31:0] c;
      c = crc_in;
      for (int i = 0; i < 8; i++)
      begin
         if (d[i] ^ c[31])
            c = (c << 1) ^ `CRC32_POLY;
         else
            c = c << 1;
      end
      return c;
   endfunction

   function automatic logic [7:0] bit_rev8(input logic [7:0] b);
      logic [7:0] r;
      for (int i = 0; i < 8; i++)
         r[i] = b[7 - i];
      return r;
   endfunction

   assign is_fcs = beat_i.valid && beat_i.kind == KIND_FCS;

   // complemented crc goes out top byte first with its msb as bit 0
   always_comb
   begin
      fcs_byte = ~bit_rev8(crc[{~fcs_idx, 3'b000} +: 8]);
      if (crc_err_i && fcs_idx == 2'(`FCS_ERR_INDEX))
         fcs_byte = ~fcs_byte;
   end

   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
      begin
         crc     <= `CRC32_INIT;
         fcs_idx <= '0;
         beat_o  <= '0;
      end
      else
      begin
         if (beat_i.valid && beat_i.first)
         begin
            crc     <= `CRC32_INIT;   // new frame
            fcs_idx <= '0;
         end
         else if (beat_i.valid && beat_i.kind == KIND_COVERED)
            crc <= crc32_byte(crc, beat_i.data);
         if (is_fcs)
            fcs_idx <= fcs_idx + 2'd1;
         beat_o <= beat_i;
         if (is_fcs)
            beat_o.data <= fcs_byte;
      end
   end

   a_fcs_run : assert property (@(posedge rx_clk_gen) disable iff (reset)
      $rose(is_fcs) |-> is_fcs [* `ETH_FCS_BYTES] ##1 !is_fcs);

endmodule

//--- rtl/gmii_rx_driver.sv
module gmii_rx_driver (
   input  logic                     rx_clk_gen,
   input  logic                     reset,
   input  gmii_gen_pkg::gmii_beat_t beat_i,
   output logic [7:0]               rxd_o,
   output logic                     rx_dv_o,
   output logic                     rx_er_o,
   output logic                     sop_o,
   output logic                     eop_o
);
   import gmii_gen_pkg::*;

   // --------------------------------------------------
   // gmii pin register
   // --------------------------------------------------
   always_ff @(posedge rx_clk_gen or posedge reset)
   begin
      if (reset)
      begin
         rxd_o   <= 8'h00;
         rx_dv_o <= 1'b0;
         rx_er_o <= 1'b0;
         sop_o   <= 1'b0;
         eop_o   <= 1'b0;
      end
      else
      begin
         rxd_o   <= beat_i.valid ? beat_i.data : 8'h00;   // quiet bus when idle
         rx_dv_o <= beat_i.valid;
         rx_er_o <= 1'b0;                                  // no phy errors generated
         sop_o   <= beat_i.valid && beat_i.first;
         eop_o   <= beat_i.valid && beat_i.last;
      end
   end

   // frame ends with dv high, and at least one idle cycle follows
   a_eop_dv : assert property (@(posedge rx_clk_gen) disable iff (reset)
      eop_o |-> rx_dv_o ##1 !rx_dv_o);

endmodule

//--- rtl/gmii_frame_gen.sv
module gmii_frame_gen (
   input  logic                     rx_clk_gen,
   input  logic                     reset,
   input  logic                     start_i,
   input  gmii_gen_pkg::frame_cmd_t cmd_i,
   output logic [7:0]               rxd_o,
   output logic                     rx_dv_o,
   output logic                     rx_er_o,
   output logic                     sop_o,
   output logic                     eop_o,
   output logic                     done_o
);
   import gmii_gen_pkg::*;

   gmii_beat_t seq_beat;           // sequencer to crc stage
   gmii_beat_t fcs_beat;           // crc stage to pins
   logic       seq_crc_err;

   frame_sequencer u_frame_sequencer (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .start_i    (start_i),
      .cmd_i      (cmd_i),
      .beat_o     (seq_beat),
      .done_o     (done_o),
      .crc_err_o  (seq_crc_err)
   );

   fcs_inserter u_fcs_inserter (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .beat_i     (seq_beat),
      .crc_err_i  (seq_crc_err),
      .beat_o     (fcs_beat)
   );

   gmii_rx_driver u_gmii_rx_driver (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .beat_i     (fcs_beat),
      .rxd_o      (rxd_o),
      .rx_dv_o    (rx_dv_o),
      .rx_er_o    (rx_er_o),
      .sop_o      (sop_o),
      .eop_o      (eop_o)
   );

endmodule

//--- sim/tb_gmii_frame_gen.sv
`include "gmii_gen_defines.svh"

module tb_gmii_frame_gen;
   timeunit 1ns;
   timeprecision 1ps;

   import gmii_gen_pkg::*;

   localparam int N_RANDOM = 20;

   logic       rx_clk_gen;
   logic       reset;
   logic       start;
   frame_cmd_t cmd;
   logic [7:0] rxd;
   logic       rx_dv;
   logic       rx_er;
   logic       sop;
   logic       eop;
   logic       done;

   frame_cmd_t cmds[$];            // every frame in send order
   logic [7:0] ref_q[$];           // expected bytes of one frame
   logic [7:0] got_q[$];           // bytes seen on rxd
   int         rx_idx      = 0;
   int         low_cnt     = 0;    // rx_dv low cycles since last frame
   int         last_ipg    = 0;
   int         err_cnt     = 0;
   int         check_cnt   = 0;
   int         cycle_cnt   = 0;
   int         cycle_limit = 1000;

   gmii_frame_gen u_dut (
      .rx_clk_gen (rx_clk_gen),
      .reset      (reset),
      .start_i    (start),
      .cmd_i      (cmd),
      .rxd_o      (rxd),
      .rx_dv_o    (rx_dv),
      .rx_er_o    (rx_er),
      .sop_o      (sop),
      .eop_o      (eop),
      .done_o     (done)
   );

   initial
   begin
      rx_clk_gen = 1'b0;
      forever #5 rx_clk_gen = ~rx_clk_gen;
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      check_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   function automatic logic [7:0] mac_byte(input logic [47:0] addr, input int i,
                                           input logic rev);
      if (rev)
         return addr[(`ETH_MAC_BYTES - 1 - i) * 8 +: 8];   // msb byte first
      return addr[i * 8 +: 8];
   endfunction

   // --------------------------------------------------
   // reference frame from preamble through fcs
   // --------------------------------------------------
   function automatic void build_ref(input frame_cmd_t c);
      logic [31:0] crc;
      logic [15:0] tpid;
      logic [15:0] len_field;
      logic [7:0]  fb;
      int          hdr_start;
      ref_q.delete();
      tpid      = `ETH_VLAN_TPID;
      hdr_start = int'(c.prmble_len) + 1;
      for (int i = 0; i < int'(c.prmble_len); i++)
         ref_q.push_back(`GMII_PREAMBLE_BYTE);
      ref_q.push_back(c.prmbl_err ? `GMII_SFD_ERR_BYTE : `GMII_SFD_BYTE);
      for (int i = 0; i < `ETH_MAC_BYTES; i++)
         ref_q.push_back(mac_byte(c.dst, i, c.mac_reverse));
      for (int i = 0; i < `ETH_MAC_BYTES; i++)
         ref_q.push_back(mac_byte(c.src, i, c.mac_reverse));
      if (c.vlan_en)
      begin
         ref_q.push_back(tpid[15:8]);
         ref_q.push_back(tpid[7:0]);
         ref_q.push_back(c.vlan_ctl[15:8]);
         ref_q.push_back(c.vlan_ctl[7:0]);
      end
      len_field = (c.frmtype != 16'd0) ? c.frmtype : c.len;
      ref_q.push_back(len_field[15:8]);
      ref_q.push_back(len_field[7:0]);
      for (int k = 0; k < int'(c.len); k++)
      begin
         if (k == 0)
            fb = c.cntstart;
         else if (k == 1)
            fb = c.cntstep;
         else
            fb = 8'(int'(c.cntstart) + (k - 2) * int'(c.cntstep));
         ref_q.push_back(fb);
      end
      while (c.pad_en && ref_q.size() - hdr_start < `ETH_MIN_FRAME_BYTES)
         ref_q.push_back(8'h00);
      // reflected crc-32 shifts right with the reversed polynomial
      crc = 32'hFFFF_FFFF;
      for (int i = hdr_start; i < ref_q.size(); i++)
      begin
         crc = crc ^ {24'h0, ref_q[i]};
         for (int b = 0; b < 8; b++)
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
      crc = ~crc;
      for (int i = 0; i < `ETH_FCS_BYTES; i++)
      begin
         fb = crc[i * 8 +: 8];     // low byte goes out first
         if (c.crc_err && i == `FCS_ERR_INDEX)
            fb = ~fb;
         ref_q.push_back(fb);
      end
   endfunction

   function automatic frame_cmd_t random_cmd();
      frame_cmd_t c;
      c             = '0;
      c.mac_reverse = 1'($urandom);
      c.dst         = {16'($urandom), $urandom};
      c.src         = {16'($urandom), $urandom};
      c.prmble_len  = 5'(1 + $urandom % 15);
      c.vlan_en     = 1'($urandom);
      c.vlan_ctl    = 16'($urandom);
      c.len         = 16'($urandom % 100);
      c.frmtype     = ($urandom % 2 == 0) ? 16'h0000 : 16'($urandom);
      c.cntstart    = 8'($urandom);
      c.cntstep     = 8'($urandom);
      c.ipg_len     = 16'($urandom % 24);
      c.prmbl_err   = ($urandom % 4 == 0);
      c.crc_err     = ($urandom % 4 == 0);
      c.pad_en      = 1'($urandom);
      return c;
   endfunction

   // start strobe once the generator reports done
   task automatic send_frame(input frame_cmd_t c);
      @(negedge rx_clk_gen);
      while (!done)
         @(negedge rx_clk_gen);
      cmd   = c;
      start = 1'b1;
      @(negedge rx_clk_gen);
      start = 1'b0;
   endtask

   task automatic compare_frame();
      int n;
      if (rx_idx >= cmds.size())
      begin
         err_cnt++;
         $display("ERROR %0t a frame came out that was never started", $time);
      end
      else
      begin
         build_ref(cmds[rx_idx]);
         check_val("rx_dv_o length", 32'(got_q.size()), 32'(ref_q.size()));
         n = (got_q.size() < ref_q.size()) ? got_q.size() : ref_q.size();
         for (int i = 0; i < n; i++)
            check_val($sformatf("rxd_o byte %0d of frame %0d", i, rx_idx),
                      32'(got_q[i]), 32'(ref_q[i]));
         last_ipg = int'(cmds[rx_idx].ipg_len);
      end
      rx_idx++;
      got_q.delete();
   endtask

   // --------------------------------------------------
   // compare process samples outputs mid-cycle
   // --------------------------------------------------
   always @(negedge rx_clk_gen)
   begin
      if (reset)
      begin
         check_val("rx_dv_o", 32'(rx_dv), 32'h0);
         check_val("rxd_o", 32'(rxd), 32'h0);
         check_val("done_o", 32'(done), 32'h1);
      end
      else
      begin
         check_val("rx_er_o", 32'(rx_er), 32'h0);
         if (rx_dv)
         begin
            if (got_q.size() == 0 && rx_idx > 0 && low_cnt < last_ipg)
            begin
               err_cnt++;
               $display("ERROR %0t rx_dv was low for only %0d cycles before frame %0d, gap %0d",
                        $time, low_cnt, rx_idx, last_ipg);
            end
            if (got_q.size() == 0)
               check_val("done_o", 32'(done), 32'h0);   // low from the start edge on
            check_val("sop_o", 32'(sop), 32'(got_q.size() == 0));
            got_q.push_back(rxd);
            low_cnt = 0;
            if (eop)
               compare_frame();
         end
         else
         begin
            low_cnt++;
            if (got_q.size() != 0)
            begin
               err_cnt++;
               $display("ERROR %0t rx_dv fell before eop in frame %0d", $time, rx_idx);
               got_q.delete();
            end
         end
      end
   end

   always @(posedge rx_clk_gen)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
      begin
         $display("timeout after %0d cycles with %0d of %0d frames received",
                  cycle_cnt, rx_idx, cmds.size());
         $display("Checks failed");
         $finish;
      end
   end

   initial
   begin
      frame_cmd_t c;
      reset = 1'b1;
      start = 1'b0;
      cmd   = '0;
      void'($urandom(32'h4817));

      c            = '0;
      c.dst        = 48'h0A1B_2C3D_4E5F;
      c.src        = 48'h0011_2233_4455;
      c.prmble_len = 5'd7;
      c.len        = 16'd46;
      c.cntstart   = 8'h20;
      c.cntstep    = 8'h07;
      c.ipg_len    = 16'd12;
      cmds.push_back(c);            // plain frame
      c.len    = 16'd10;
      c.pad_en = 1'b1;
      cmds.push_back(c);            // short padded payload
      c.pad_en = 1'b0;
      cmds.push_back(c);
      c.len         = 16'd40;
      c.vlan_en     = 1'b1;
      c.vlan_ctl    = 16'hA123;
      c.mac_reverse = 1'b1;
      c.frmtype     = 16'h0800;
      cmds.push_back(c);            // tagged frame with reversed addresses
      c           = cmds[0];
      c.prmbl_err = 1'b1;
      c.crc_err   = 1'b1;
      cmds.push_back(c);
      for (int i = 0; i < N_RANDOM; i++)
         cmds.push_back(random_cmd());

      // frames, gaps and a little slack per start
      cycle_limit = 200 + 8;
      foreach (cmds[i])
      begin
         build_ref(cmds[i]);
         cycle_limit += ref_q.size() + int'(cmds[i].ipg_len) + 4;
      end

      repeat (8) @(negedge rx_clk_gen);
      reset = 1'b0;
      foreach (cmds[i])
         send_frame(cmds[i]);
      while (rx_idx < cmds.size() || !done)
         @(negedge rx_clk_gen);

      $display("checks %0d, errors %0d, frames %0d", check_cnt, err_cnt, rx_idx);
      if (err_cnt == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

//--- gmii_frame_gen.f
+incdir+rtl
rtl/gmii_gen_pkg.sv
rtl/frame_sequencer.sv
rtl/fcs_inserter.sv
rtl/gmii_rx_driver.sv
rtl/gmii_frame_gen.sv
sim/tb_gmii_frame_gen.sv

//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_gmii_frame_gen -f gmii_frame_gen.f -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
